/* common/pool_pkg.sv */
package pool_pkg;

	// Datapath geometry
	localparam int BURST_LEN = 16;  // Lanes per atom, words per DMA burst
	localparam int DATA_W    = 16;  // One feature element
	localparam int ACC_W     = 24;  // Lane sum for average pooling
	localparam int ADDR_W    = 30;  // DMA word address

	// Job limits
	localparam int ATOMS_MAX = 16;  // k*k with k up to 4
	localparam int OSIDE_W   = 6;   // Holds o_side up to 32
	localparam int KERN_W    = 3;   // Kernel and stride fields

	// Counter widths
	localparam int LANE_IDX_W = $clog2(BURST_LEN);  // Word index inside a burst
	localparam int ATOM_IDX_W = $clog2(ATOMS_MAX);  // Atom index inside a window

	// Operation codes on i_op
	localparam logic OP_MAX = 1'b0;  // Signed maximum
	localparam logic OP_AVG = 1'b1;  // Shifted sum

	// Job FSM encoding
	localparam logic [1:0] CTRL_IDLE  = 2'd0;
	localparam logic [1:0] CTRL_BUSY  = 2'd1;  // Window in fetch or waiting to launch
	localparam logic [1:0] CTRL_CLEAR = 2'd2;  // Step to next window

	// One atom or one pooled result, lane n = channel n
	typedef logic [BURST_LEN-1:0][DATA_W-1:0] lane_vec_t;

endpackage

/* design/engine_ctrl.sv */
module engine_ctrl import pool_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_start,       // Taken only in idle
	input  logic [KERN_W-1:0]  i_stride,
	input  logic [OSIDE_W-1:0] i_o_side,
	input  logic [ADDR_W-1:0]  i_src_addr,
	input  logic               i_win_fetched, // Last atom of current window is out
	input  logic               i_res_pending, // pool_lanes still holds a result
	input  logic               i_wr_done,     // One result burst finished
	output logic               o_busy,
	output logic               o_done,
	output logic               o_win_start,
	output logic [ADDR_W-1:0]  o_win_base
);

	logic [1:0]         state;
	logic               launch;       // Next window waits for its start pulse
	logic [OSIDE_W-1:0] fetched_cnt;  // Windows fully read
	logic [OSIDE_W-1:0] written_cnt;  // Results fully written
	logic [ADDR_W-1:0]  stride_step;  // Window pitch in words

	assign o_busy      = (state != CTRL_IDLE);
	assign stride_step = ADDR_W'(i_stride) * ADDR_W'(BURST_LEN);

	// Start is held back until the previous result has left pool_lanes,
	// so at most one finished result ever waits there
	assign o_win_start = (state == CTRL_BUSY) && launch && !i_res_pending;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= CTRL_IDLE;
			launch      <= 1'b0;
			fetched_cnt <= '0;
			written_cnt <= '0;
			o_win_base  <= '0;
			o_done      <= 1'b0;
		end else begin
			o_done <= 1'b0;  // Single-cycle pulse
			case (state)
				CTRL_IDLE: begin
					if (i_start) begin
						state       <= CTRL_BUSY;
						launch      <= 1'b1;  // First window goes out next cycle
						fetched_cnt <= '0;
						written_cnt <= '0;
						o_win_base  <= i_src_addr;  // Window 0 starts at column 0
					end
				end
				CTRL_BUSY: begin
					if (o_win_start)
						launch <= 1'b0;
					if (i_win_fetched)
						state <= CTRL_CLEAR;
				end
				CTRL_CLEAR: begin
					// One cycle to step the base before the next launch
					fetched_cnt <= fetched_cnt + 1'b1;
					o_win_base  <= o_win_base + stride_step;
					launch      <= (fetched_cnt + 1'b1 < i_o_side);
					state       <= CTRL_BUSY;
				end
				default: state <= CTRL_IDLE;
			endcase

			// Writes drain in any active state including clear
			if (o_busy && i_wr_done) begin
				written_cnt <= written_cnt + 1'b1;
				if (written_cnt + 1'b1 == i_o_side && fetched_cnt == i_o_side) begin
					o_done <= 1'b1;
					state  <= CTRL_IDLE;
				end
			end
		end
	end

	// A fetched window must be one that was launched and is still awaited in busy
	a_fetched_in_busy: assert property (@(posedge clk) disable iff (rst)
		i_win_fetched |-> (state == CTRL_BUSY && !launch))
		else $error("window fetched outside busy state or before its launch");

endmodule

/* design/pool_engine.sv */
module pool_engine import pool_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	// Host job interface
	input  logic              i_start,
	input  logic              i_op,
	input  logic [KERN_W-1:0] i_kernel,
	input  logic [KERN_W-1:0] i_stride,
	input  logic [7:0]        i_i_side,
	input  logic [OSIDE_W-1:0] i_o_side,
	input  logic [ADDR_W-1:0] i_src_addr,
	input  logic [ADDR_W-1:0] i_dst_addr,
	output logic              o_busy,
	output logic              o_done,
	// DMA read port
	output logic              o_rd_en,
	output logic [ADDR_W-1:0] o_rd_addr,
	input  logic [DATA_W-1:0] i_rd_data,
	input  logic              i_rd_we,
	// DMA write port
	output logic              o_wr_en,
	output logic [ADDR_W-1:0] o_wr_addr,
	input  logic              i_wr_re,
	output logic [DATA_W-1:0] o_wr_data,
	output logic              o_wr_valid
);

	logic              win_start;    // Ctrl launches one window
	logic [ADDR_W-1:0] win_base;     // Top-left atom of that window
	logic              win_fetched;  // Last atom of window delivered
	logic              atom_valid;
	lane_vec_t         atom;
	logic              win_first;
	logic              win_last;
	logic              res_valid;    // Result held in pool_lanes
	lane_vec_t         res;
	logic              res_take;
	logic              wr_done;      // One result burst written

	engine_ctrl u_engine_ctrl (
		.clk           (clk),
		.rst           (rst),
		.i_start       (i_start),
		.i_stride      (i_stride),
		.i_o_side      (i_o_side),
		.i_src_addr    (i_src_addr),
		.i_win_fetched (win_fetched),
		.i_res_pending (res_valid),
		.i_wr_done     (wr_done),
		.o_busy        (o_busy),
		.o_done        (o_done),
		.o_win_start   (win_start),
		.o_win_base    (win_base)
	);

	atom_fetch u_atom_fetch (
		.clk           (clk),
		.rst           (rst),
		.i_win_start   (win_start),
		.i_win_base    (win_base),
		.i_kernel      (i_kernel),
		.i_i_side      (i_i_side),
		.i_rd_data     (i_rd_data),
		.i_rd_we       (i_rd_we),
		.o_rd_en       (o_rd_en),
		.o_rd_addr     (o_rd_addr),
		.o_atom_valid  (atom_valid),
		.o_atom        (atom),
		.o_win_first   (win_first),
		.o_win_last    (win_last),
		.o_win_fetched (win_fetched)
	);

	pool_lanes u_pool_lanes (
		.clk          (clk),
		.rst          (rst),
		.i_op         (i_op),
		.i_kernel     (i_kernel),
		.i_atom_valid (atom_valid),
		.i_atom       (atom),
		.i_win_first  (win_first),
		.i_win_last   (win_last),
		.i_res_take   (res_take),
		.o_res_valid  (res_valid),
		.o_res        (res)
	);

	result_writer u_result_writer (
		.clk         (clk),
		.rst         (rst),
		.i_done      (o_done),  // Rewinds destination offset per job
		.i_dst_addr  (i_dst_addr),
		.i_res_valid (res_valid),
		.i_res       (res),
		.i_wr_re     (i_wr_re),
		.o_res_take  (res_take),
		.o_wr_en     (o_wr_en),
		.o_wr_addr   (o_wr_addr),
		.o_wr_data   (o_wr_data),
		.o_wr_valid  (o_wr_valid),
		.o_wr_done   (wr_done)
	);

endmodule

/* dv/dma_sim.sv */
module dma_sim import pool_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  int                i_gap_pct,   // Chance of an idle cycle per word
	input  logic              i_rd_en,
	input  logic [ADDR_W-1:0] i_rd_addr,
	output logic [DATA_W-1:0] o_rd_data,
	output logic              o_rd_we,
	input  logic              i_wr_en,
	input  logic [ADDR_W-1:0] i_wr_addr,
	output logic              o_wr_re,
	input  logic [DATA_W-1:0] i_wr_data,
	input  logic              i_wr_valid
);

	logic [DATA_W-1:0] mem [4096];  // Source feature map
	logic [DATA_W-1:0] wmem [int];  // Written words by address
	int                wr_bursts [$];  // Address of each write burst
	int                proto_errs;
	int                rd_left;
	int                wr_left;
	int                wr_idx;
	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W-1:0] wr_base;
	logic              re_prev;  // A pull went out last cycle

	function automatic bit gap();
		return $urandom_range(99) < i_gap_pct;
	endfunction

	task automatic fill();
		for (int i = 0; i < 4096; i++)
			mem[i] = DATA_W'($urandom);
	endtask

	task automatic clear_writes();
		wmem.delete();
		wr_bursts.delete();
	endtask

	initial begin
		o_rd_data  = '0;
		o_rd_we    = 1'b0;
		o_wr_re    = 1'b0;
		rd_left    = 0;
		wr_left    = 0;
		wr_idx     = 0;
		re_prev    = 1'b0;
		proto_errs = 0;
		forever begin
			@(posedge clk);
			#2;  // After the testbench drives its inputs
			o_rd_we = 1'b0;
			o_wr_re = 1'b0;
			if (rst) begin
				rd_left = 0;  // Drop any burst in flight
				wr_left = 0;
				re_prev = 1'b0;
			end else begin
				// Read side, first word one cycle after the request
				if (rd_left > 0 && !gap()) begin
					o_rd_data = mem[rd_ptr[11:0]];
					o_rd_we   = 1'b1;
					rd_ptr    = rd_ptr + 1'b1;
					rd_left--;
				end
				if (i_rd_en) begin
					rd_left = BURST_LEN;
					rd_ptr  = i_rd_addr;
				end
				// Valid must follow its pull by one cycle
				if (i_wr_valid != re_prev) begin
					$display("** Error @%0t: o_wr_valid=%0b, pull one cycle before=%0b",
						$time, i_wr_valid, re_prev);
					proto_errs++;
				end
				if (i_wr_valid) begin
					wmem[int'(wr_base) + wr_idx] = i_wr_data;
					wr_idx++;
				end
				re_prev = 1'b0;
				if (wr_left > 0 && !gap()) begin
					o_wr_re = 1'b1;
					re_prev = 1'b1;
					wr_left--;
				end
				if (i_wr_en) begin  // Pulls start next cycle
					wr_left = BURST_LEN;
					wr_base = i_wr_addr;
					wr_idx  = 0;
					wr_bursts.push_back(int'(i_wr_addr));
				end
			end
		end
	end

endmodule

/* dv/tb_clock.sv */
module tb_clock (
	output logic o_clk
);

	// Free running clock, period 8
	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;
	end

endmodule

/* dv/tb_pool_engine.sv */
module tb_pool_engine import pool_pkg::*; ();

	localparam int NJOBS      = 20;
	localparam int JOB_CYCLES = 20000;
	localparam int TOTAL_JOBS = 3 * NJOBS + 3 + 2;  // All tests together

	logic              clk;
	logic              rst;
	logic              i_start;
	logic              i_op;
	logic [KERN_W-1:0] i_kernel;
	logic [KERN_W-1:0] i_stride;
	logic [7:0]        i_i_side;
	logic [OSIDE_W-1:0] i_o_side;
	logic [ADDR_W-1:0] i_src_addr;
	logic [ADDR_W-1:0] i_dst_addr;
	logic              o_busy, o_done, o_rd_en, o_wr_en, o_wr_valid;
	logic [ADDR_W-1:0] o_rd_addr, o_wr_addr;
	logic [DATA_W-1:0] i_rd_data, o_wr_data;
	logic              i_rd_we, i_wr_re;
	int                gap_pct;
	int                err_cnt, pass_cnt, fail_cnt, mark;
	int                pk [NJOBS], ps [NJOBS], po [NJOBS];
	int                pi [NJOBS], psrc [NJOBS], pdst [NJOBS];

	tb_clock u_tb_clock (.o_clk(clk));

	pool_engine u_pool_engine (
		.clk(clk), .rst(rst), .i_start(i_start), .i_op(i_op), .i_kernel(i_kernel),
		.i_stride(i_stride), .i_i_side(i_i_side), .i_o_side(i_o_side),
		.i_src_addr(i_src_addr), .i_dst_addr(i_dst_addr), .o_busy(o_busy), .o_done(o_done),
		.o_rd_en(o_rd_en), .o_rd_addr(o_rd_addr), .i_rd_data(i_rd_data), .i_rd_we(i_rd_we),
		.o_wr_en(o_wr_en), .o_wr_addr(o_wr_addr), .i_wr_re(i_wr_re),
		.o_wr_data(o_wr_data), .o_wr_valid(o_wr_valid)
	);

	dma_sim u_dma (
		.clk(clk), .rst(rst), .i_gap_pct(gap_pct), .i_rd_en(o_rd_en), .i_rd_addr(o_rd_addr),
		.o_rd_data(i_rd_data), .o_rd_we(i_rd_we), .i_wr_en(o_wr_en), .i_wr_addr(o_wr_addr),
		.o_wr_re(i_wr_re), .i_wr_data(o_wr_data), .i_wr_valid(o_wr_valid)
	);

	// Random job shape with i_side wide enough for the last window
	task automatic make_job(input int idx);
		int k;
		k         = 1 << $urandom_range(2);
		pk[idx]   = k;
		ps[idx]   = $urandom_range(k, 1);
		po[idx]   = $urandom_range(8, 1);
		pi[idx]   = (po[idx] - 1) * ps[idx] + k + $urandom_range(3);
		psrc[idx] = $urandom_range(4096 - k * pi[idx] * BURST_LEN);
		pdst[idx] = 32'h10000 + $urandom_range(255) * BURST_LEN;
	endtask

	// Reference pooling of one lane of output j
	function automatic logic [DATA_W-1:0] expect_word(input logic op, input int k, input int st,
		input int is, input int src, input int j, input int n);
		int v, sum, mx, sh, addr;
		sum = 0;
		mx  = -32768;
		for (int r = 0; r < k; r++) begin
			for (int c = 0; c < k; c++) begin
				addr = (src + (r * is + j * st + c) * BURST_LEN + n) % 4096;
				v    = int'($signed(u_dma.mem[addr]));
				sum  = sum + v;
				if (v > mx)
					mx = v;
			end
		end
		sh = (k == 4) ? 4 : (k == 2) ? 2 : 0;  // 2*log2(k)
		return (op == OP_MAX) ? DATA_W'(mx) : DATA_W'(sum >>> sh);
	endfunction

	task automatic run_job(input logic op, input int idx, input int gap);
		int done_cnt, cyc, a;
		logic [DATA_W-1:0] exp_w;
		gap_pct = gap;
		u_dma.clear_writes();
		@(posedge clk);
		#1;
		i_op       = op;
		i_kernel   = KERN_W'(pk[idx]);
		i_stride   = KERN_W'(ps[idx]);
		i_i_side   = 8'(pi[idx]);
		i_o_side   = OSIDE_W'(po[idx]);
		i_src_addr = ADDR_W'(psrc[idx]);
		i_dst_addr = ADDR_W'(pdst[idx]);
		i_start    = 1'b1;
		@(posedge clk);
		#1;
		i_start  = 1'b0;
		done_cnt = 0;
		cyc      = 0;
		while (done_cnt == 0 && cyc < JOB_CYCLES) begin
			@(posedge clk);
			#1;
			cyc++;
			if (o_done)
				done_cnt++;
		end
		if (done_cnt == 0) begin
			$display("job %0d never raised o_done within %0d cycles", idx, JOB_CYCLES);
			err_cnt++;
		end
		repeat (4) begin  // Look for stray extra done pulses
			@(posedge clk);
			#1;
			if (o_done)
				done_cnt++;
		end
		if (done_cnt > 1) begin
			$display("** Error @%0t: job %0d gave %0d o_done pulses instead of one",
				$time, idx, done_cnt);
			err_cnt++;
		end
		if (o_busy) begin
			$display("job %0d left o_busy high after o_done", idx);
			err_cnt++;
		end
		if (u_dma.wr_bursts.size() != po[idx]) begin
			$display("** Error @%0t: job %0d wrote %0d bursts, expected %0d", $time, idx,
				u_dma.wr_bursts.size(), po[idx]);
			err_cnt++;
		end else begin
			for (int j = 0; j < po[idx]; j++)
				if (u_dma.wr_bursts[j] != pdst[idx] + j * BURST_LEN) begin
					$display("** Error @%0t: burst %0d at %0h, expected %0h", $time, j,
						u_dma.wr_bursts[j], pdst[idx] + j * BURST_LEN);
					err_cnt++;
				end
		end
		if (u_dma.wmem.size() != po[idx] * BURST_LEN) begin
			$display("** Error @%0t: job %0d wrote %0d words, expected %0d", $time, idx,
				u_dma.wmem.size(), po[idx] * BURST_LEN);
			err_cnt++;
		end
		for (int j = 0; j < po[idx]; j++) begin
			for (int n = 0; n < BURST_LEN; n++) begin
				a     = pdst[idx] + j * BURST_LEN + n;
				exp_w = expect_word(op, pk[idx], ps[idx], pi[idx], psrc[idx], j, n);
				if (!u_dma.wmem.exists(a)) begin
					$display("job %0d result %0d lane %0d was never written", idx, j, n);
					err_cnt++;
				end else if (u_dma.wmem[a] != exp_w) begin
					$display("** Error @%0t: op %0b k %0d out %0d lane %0d got %h expected %h",
						$time, op, pk[idx], j, n, u_dma.wmem[a], exp_w);
					err_cnt++;
				end
			end
		end
	endtask

	task automatic report(input string name);
		int errs;
		errs = err_cnt + u_dma.proto_errs - mark;
		if (errs == 0) begin
			pass_cnt++;
			$display("test %s: pass", name);
		end else begin
			fail_cnt++;
			$display("test %s: FAIL with %0d errors", name, errs);
		end
		mark = err_cnt + u_dma.proto_errs;
	endtask

	// Watchdog sized by the job count
	initial begin
		#(TOTAL_JOBS * JOB_CYCLES * 8);
		$display("watchdog expired, the run did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		void'($urandom(32'haaa5a152));
		rst        = 1'b1;
		i_start    = 1'b0;
		i_op       = OP_MAX;
		i_kernel   = 3'd1;
		i_stride   = 3'd1;
		i_i_side   = 8'd1;
		i_o_side   = 6'd1;
		i_src_addr = '0;
		i_dst_addr = '0;
		gap_pct    = 0;
		err_cnt    = 0;
		pass_cnt   = 0;
		fail_cnt   = 0;
		mark       = 0;
		u_dma.fill();
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		if (o_busy || o_done) begin  // Idle after reset
			$display("** Error @%0t: o_busy or o_done high after reset", $time);
			err_cnt++;
		end
		for (int i = 0; i < NJOBS; i++)
			make_job(i);
		for (int i = 0; i < NJOBS; i++)
			run_job(OP_MAX, i, 0);
		report("max_pool");
		for (int i = 0; i < NJOBS; i++)
			run_job(OP_AVG, i, 0);
		report("avg_pool");
		for (int i = 0; i < NJOBS; i++) begin
			make_job(i);
			run_job(1'($urandom_range(1)), i, 30);
		end
		report("dma_gaps");
		for (int i = 0; i < 3; i++)
			run_job(OP_MAX, i, 50);  // Framing checked in every job
		report("job_framing");
		// Abort a long job partway through
		gap_pct = 0;
		@(posedge clk);
		#1;
		i_op       = OP_MAX;
		i_kernel   = 3'd4;
		i_stride   = 3'd2;
		i_i_side   = 8'd20;
		i_o_side   = 6'd8;
		i_src_addr = '0;
		i_dst_addr = ADDR_W'(32'h10000);
		i_start    = 1'b1;
		@(posedge clk);
		#1;
		i_start = 1'b0;
		repeat (40) @(posedge clk);
		#1;
		if (!o_busy) begin
			$display("job was not busy when reset was applied");
			err_cnt++;
		end
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		if (o_busy || o_done || o_rd_en || o_wr_en || o_wr_valid) begin
			$display("** Error @%0t: outputs still active during reset", $time);
			err_cnt++;
		end
		rst = 1'b0;
		make_job(1);
		run_job(OP_MAX, 1, 0);
		report("reset_mid_job");
		$display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, mark);
		if (fail_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* fetch/atom_fetch.sv */
module atom_fetch import pool_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_win_start,
	input  logic [ADDR_W-1:0] i_win_base,  // Atom (0, j*stride)
	input  logic [KERN_W-1:0] i_kernel,
	input  logic [7:0]        i_i_side,
	input  logic [DATA_W-1:0] i_rd_data,
	input  logic              i_rd_we,
	output logic              o_rd_en,
	output logic [ADDR_W-1:0] o_rd_addr,
	output logic              o_atom_valid,
	output lane_vec_t         o_atom,
	output logic              o_win_first,
	output logic              o_win_last,
	output logic              o_win_fetched
);

	logic                  rd_pend;     // Window active, a burst is outstanding
	logic [LANE_IDX_W-1:0] word_cnt;
	logic [ATOM_IDX_W-1:0] atom_cnt;    // Atom index in k*k walk
	logic [KERN_W-1:0]     col_cnt;     // Column inside current window row
	logic [ATOM_IDX_W:0]   atom_total;  // k*k, up to 16
	logic                  win_end;
	logic                  row_end;
	logic [ADDR_W-1:0]     row_step;    // Jump from row end to next row start
	lane_vec_t             atom_buf;

	assign atom_total = (ATOM_IDX_W + 1)'(i_kernel) * (ATOM_IDX_W + 1)'(i_kernel);
	assign win_end    = ({1'b0, atom_cnt} == atom_total - 1'b1);
	assign row_end    = (col_cnt == i_kernel - 1'b1);
	// From column c+k-1 to column c of the next row
	assign row_step   = (ADDR_W'(i_i_side) - ADDR_W'(i_kernel) + 1'b1) * ADDR_W'(BURST_LEN);
	assign o_atom     = atom_buf;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_rd_en       <= 1'b0;
			o_rd_addr     <= '0;
			rd_pend       <= 1'b0;
			word_cnt      <= '0;
			atom_cnt      <= '0;
			col_cnt       <= '0;
			o_atom_valid  <= 1'b0;
			o_win_first   <= 1'b0;
			o_win_last    <= 1'b0;
			o_win_fetched <= 1'b0;
		end else begin
			o_rd_en       <= 1'b0;  // Pulses
			o_atom_valid  <= 1'b0;
			o_win_fetched <= 1'b0;
			if (i_win_start) begin
				o_rd_en   <= 1'b1;
				o_rd_addr <= i_win_base;
				rd_pend   <= 1'b1;
				word_cnt  <= '0;
				atom_cnt  <= '0;
				col_cnt   <= '0;
			end else if (rd_pend && i_rd_we) begin
				word_cnt <= word_cnt + 1'b1;  // Wraps after the last lane
				if (word_cnt == LANE_IDX_W'(BURST_LEN - 1)) begin
					o_atom_valid  <= 1'b1;
					o_win_first   <= (atom_cnt == '0);
					o_win_last    <= win_end;
					o_win_fetched <= win_end;
					if (win_end) begin
						rd_pend <= 1'b0;  // Window done, wait for ctrl
					end else begin
						// Next burst goes out together with atom_valid
						o_rd_en  <= 1'b1;
						atom_cnt <= atom_cnt + 1'b1;
						if (row_end) begin
							col_cnt   <= '0;
							o_rd_addr <= o_rd_addr + row_step;
						end else begin
							col_cnt   <= col_cnt + 1'b1;
							o_rd_addr <= o_rd_addr + ADDR_W'(BURST_LEN);
						end
					end
				end
			end
		end
	end

	// Words enter at the top lane and move down, word n ends in lane n
	always_ff @(posedge clk) begin
		if (i_rd_we)
			atom_buf <= {i_rd_data, atom_buf[BURST_LEN-1:1]};
	end

	// DMA must only return words for a burst this block requested
	a_rd_we_pending: assert property (@(posedge clk) disable iff (rst)
		i_rd_we |-> rd_pend)
		else $error("read word arrived with no burst outstanding");

endmodule

/* pool/pool_lanes.sv */
module pool_lanes import pool_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_op,
	input  logic [KERN_W-1:0] i_kernel,
	input  logic              i_atom_valid,
	input  lane_vec_t         i_atom,
	input  logic              i_win_first,  // Load instead of combine
	input  logic              i_win_last,   // Form and hold the result
	input  logic              i_res_take,
	output logic              o_res_valid,
	output lane_vec_t         o_res
);

	logic signed [ACC_W-1:0] acc      [BURST_LEN];  // Running max or sum per lane
	logic signed [ACC_W-1:0] acc_nxt  [BURST_LEN];
	logic signed [ACC_W-1:0] word_ext [BURST_LEN];
	logic signed [ACC_W-1:0] avg_val  [BURST_LEN];
	logic [KERN_W-1:0]       avg_shift;

	// 2*log2(k) for k in {1,2,4}, i.e. divide by k*k
	assign avg_shift = {i_kernel[2:1], 1'b0};

	always_comb begin
		for (int n = 0; n < BURST_LEN; n++) begin
			word_ext[n] = {{(ACC_W - DATA_W){i_atom[n][DATA_W-1]}}, i_atom[n]};  // Sign extend
			if (i_win_first)
				acc_nxt[n] = word_ext[n];
			else if (i_op == OP_MAX)
				acc_nxt[n] = (word_ext[n] > acc[n]) ? word_ext[n] : acc[n];  // Signed compare
			else
				acc_nxt[n] = acc[n] + word_ext[n];
			avg_val[n] = acc_nxt[n] >>> avg_shift;  // Arithmetic shift keeps sign
		end
	end

	// Lane state
	always_ff @(posedge clk) begin
		if (i_atom_valid) begin
			for (int n = 0; n < BURST_LEN; n++)
				acc[n] <= acc_nxt[n];
		end
	end

	// Result is taken from the updated value, last atom included
	always_ff @(posedge clk) begin
		if (i_atom_valid && i_win_last) begin
			for (int n = 0; n < BURST_LEN; n++)
				o_res[n] <= (i_op == OP_MAX) ? acc_nxt[n][DATA_W-1:0] : avg_val[n][DATA_W-1:0];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_res_valid <= 1'b0;
		end else if (i_atom_valid && i_win_last) begin
			o_res_valid <= 1'b1;  // Held until the writer takes it
		end else if (i_res_take) begin
			o_res_valid <= 1'b0;
		end
	end

	// Ctrl throttling must keep a new window from finishing on top of
	// a result the writer has not taken yet
	a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
		(i_atom_valid && i_win_last) |-> !o_res_valid)
		else $error("window finished while previous result still held");

endmodule

/* run.sh */
#!/bin/sh
# Build and run the pooling engine testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module tb_pool_engine \
	--Mdir obj_dir -o tb_pool_engine > build.log 2>&1 &&
./obj_dir/tb_pool_engine > sim.log 2>&1 ||
{ echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* sim.f */
common/pool_pkg.sv
design/engine_ctrl.sv
fetch/atom_fetch.sv
pool/pool_lanes.sv
writeback/result_writer.sv
design/pool_engine.sv
dv/tb_clock.sv
dv/dma_sim.sv
dv/tb_pool_engine.sv

/* writeback/result_writer.sv */
module result_writer import pool_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_done,      // Job finished, rewind destination
	input  logic [ADDR_W-1:0] i_dst_addr,
	input  logic              i_res_valid,
	input  lane_vec_t         i_res,
	input  logic              i_wr_re,     // DMA pulls one word
	output logic              o_res_take,
	output logic              o_wr_en,
	output logic [ADDR_W-1:0] o_wr_addr,
	output logic [DATA_W-1:0] o_wr_data,
	output logic              o_wr_valid,
	output logic              o_wr_done
);

	logic                  sending;  // Burst in progress
	logic [LANE_IDX_W-1:0] lane;     // Next lane to send
	logic [ADDR_W-1:0]     dst_off;  // j*16 for the next result
	lane_vec_t             res_buf;

	// Take and request in the same cycle, straight from idle
	assign o_res_take = i_res_valid && !sending;
	assign o_wr_en    = o_res_take;
	assign o_wr_addr  = i_dst_addr + dst_off;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sending    <= 1'b0;
			lane       <= '0;
			dst_off    <= '0;
			o_wr_valid <= 1'b0;
			o_wr_done  <= 1'b0;
		end else begin
			o_wr_valid <= 1'b0;
			o_wr_done  <= 1'b0;
			if (i_done)
				dst_off <= '0;
			if (o_res_take) begin
				sending <= 1'b1;
				lane    <= '0;
				dst_off <= dst_off + ADDR_W'(BURST_LEN);
			end else if (o_wr_done) begin
				sending <= 1'b0;  // Idle from the cycle after last valid
			end
			if (sending && i_wr_re) begin
				o_wr_valid <= 1'b1;
				lane       <= lane + 1'b1;
				if (lane == LANE_IDX_W'(BURST_LEN - 1))
					o_wr_done <= 1'b1;  // Coincides with last o_wr_valid
			end
		end
	end

	// Result copy and outgoing word
	always_ff @(posedge clk) begin
		if (o_res_take)
			res_buf <= i_res;
		if (i_wr_re)
			o_wr_data <= res_buf[lane];  // Lane 0 first
	end

	// DMA only pulls words after a write request of ours
	a_wr_re_active: assert property (@(posedge clk) disable iff (rst)
		i_wr_re |-> sending)
		else $error("write pull while no burst is active");

endmodule
